//--- all.f
+incdir+design
design/mips_pkg.sv
design/reg_port_if.sv
design/alu_if.sv
design/mips_alu.sv
design/mips_reg_file.sv
design/mips_controller.sv
design/mips_cpu.sv
testbench/tb_avalon_ram.sv
testbench/tb_mips_cpu.sv

//--- design/alu_if.sv
`timescale 1ns/100ps
`include "mips_macros.svh"

interface alu_if import mips_pkg::*; ();

    alu_op_e                 op;
    logic [`MIPS_DATA_W-1:0] a;
    logic [`MIPS_DATA_W-1:0] b;
    logic [`MIPS_DATA_W-1:0] result;
    logic                    equal;     // Set when a equals b.
    logic                    negative;  // Sign bit of a alone.

    modport controller (output op, a, b, input result, equal, negative);

    modport alu (input op, a, b, output result, equal, negative);

endinterface

//--- design/mips_alu.sv
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_alu import mips_pkg::*; (
    alu_if.alu alu
);

    logic [`MIPS_DATA_W-1:0] sum;
    logic [`MIPS_DATA_W-1:0] diff;

    assign sum  = alu.a + alu.b;
    assign diff = alu.a - alu.b;  // Also feeds the equality flag for BEQ and BNE.

    always_comb begin
        case (alu.op)
            ALU_ADD: begin
                alu.result = sum;
            end
            ALU_SUB: begin
                alu.result = diff;
            end
            ALU_AND: begin
                alu.result = alu.a & alu.b;
            end
            ALU_OR: begin
                alu.result = alu.a | alu.b;
            end
            ALU_LUI: begin
                alu.result = {alu.b[15:0], 16'h0000};  // Immediate into the upper half.
            end
            default: begin
                alu.result = '0;
            end
        endcase
    end

    assign alu.equal    = (diff == '0);
    assign alu.negative = alu.a[`MIPS_DATA_W-1];  // BLTZ and BGEZ look only at rs.

    // The decoder in the controller must only ever select one of the defined operations,
    // even while the instruction register still holds an unknown word.
    always_comb begin
        a_op_known: assert final (alu.op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_LUI})
            else $error("ALU operation %0d is not a defined operation.", alu.op);
    end

endmodule

//--- design/mips_controller.sv
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_controller import mips_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic                        active,
    output logic [`MIPS_DATA_W-1:0]     address,
    output logic                        read,
    output logic                        write,
    output logic [`MIPS_DATA_W-1:0]     writedata,
    output logic [`MIPS_DATA_W/8-1:0]   byteenable,
    input  logic                        waitrequest,
    input  logic [`MIPS_DATA_W-1:0]     readdata,
    reg_port_if.controller              regs,
    alu_if.controller                   alu
);

    ctrl_state_e             state;
    logic [`MIPS_DATA_W-1:0] pc;        // Address of the instruction in flight.
    logic [`MIPS_DATA_W-1:0] npc;       // Address of the next one, delay slot included.
    logic [`MIPS_DATA_W-1:0] ir;
    logic [`MIPS_DATA_W-1:0] rs_q;
    logic [`MIPS_DATA_W-1:0] rt_q;
    logic [`MIPS_DATA_W-1:0] alu_q;
    logic [`MIPS_DATA_W-1:0] mem_q;
    logic [`MIPS_DATA_W-1:0] target_q;  // Pending control-transfer target.
    logic                    jump_q;    // Target takes effect after the delay slot.

    opcode_e                 opcode;
    funct_e                  funct;
    regimm_e                 rt_code;
    alu_op_e                 alu_op;
    logic [`MIPS_DATA_W-1:0] imm_ext;
    logic [`MIPS_DATA_W-1:0] br_target;
    logic use_imm;
    logic zero_ext;
    logic reg_write;
    logic dest_rd;
    logic is_load;
    logic is_store;
    logic branch_taken;
    logic fetch_done;
    logic mem_done;
    logic halting;

    assign opcode  = opcode_e'(ir[31:26]);
    assign funct   = funct_e'(ir[5:0]);
    assign rt_code = regimm_e'(ir[20:16]);

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        zero_ext  = 1'b0;
        reg_write = 1'b0;
        dest_rd   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dest_rd = 1'b1;
                case (funct)
                    FN_ADDU: begin
                        alu_op    = ALU_ADD;
                        reg_write = 1'b1;
                    end
                    FN_SUBU: begin
                        alu_op    = ALU_SUB;
                        reg_write = 1'b1;
                    end
                    FN_AND: begin
                        alu_op    = ALU_AND;
                        reg_write = 1'b1;
                    end
                    FN_OR: begin
                        alu_op    = ALU_OR;
                        reg_write = 1'b1;
                    end
                    default: ;  // JR writes no register.
                endcase
            end
            OP_ADDIU: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_ANDI, OP_ORI: begin
                alu_op    = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                use_imm   = 1'b1;
                zero_ext  = 1'b1;  // Logical immediates are zero-extended.
                reg_write = 1'b1;
            end
            OP_LUI: begin
                alu_op    = ALU_LUI;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LW: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                is_load   = 1'b1;
            end
            OP_SW: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                alu_op = ALU_SUB;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_BEQ:     branch_taken = alu.equal;
            OP_BNE:     branch_taken = !alu.equal;
            OP_SPECIAL: branch_taken = (funct == FN_JR);
            OP_REGIMM: begin
                case (rt_code)
                    RI_BLTZ: branch_taken = alu.negative;
                    RI_BGEZ: branch_taken = !alu.negative;
                    default: branch_taken = 1'b0;
                endcase
            end
            default:    branch_taken = 1'b0;
        endcase
    end

    assign imm_ext   = {{(`MIPS_DATA_W-16){ir[15] & !zero_ext}}, ir[15:0]};
    assign br_target = npc + {{(`MIPS_DATA_W-18){ir[15]}}, ir[15:0], 2'b00};  // Relative to the slot.

    assign alu.op = alu_op;
    assign alu.a  = rs_q;
    assign alu.b  = use_imm ? imm_ext : rt_q;

    assign regs.rs_addr = ir[25:21];
    assign regs.rt_addr = ir[20:16];
    assign regs.wr_en   = (state == S_WRITEBACK) && reg_write;
    assign regs.wr_addr = dest_rd ? ir[15:11] : ir[20:16];
    assign regs.wr_data = is_load ? mem_q : alu_q;

    assign read       = ((state == S_FETCH) && active) || ((state == S_MEM) && is_load);
    assign write      = (state == S_MEM) && is_store;
    assign address    = (state == S_MEM) ? alu_q : pc;
    assign writedata  = rt_q;
    assign byteenable = '1;  // Only full-word accesses.

    assign fetch_done = (state == S_FETCH) && active && !waitrequest;
    assign mem_done   = (state == S_MEM) && !waitrequest;
    assign halting    = (state == S_WRITEBACK) && (npc == `MIPS_HALT_ADDR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= S_FETCH;
            active <= 1'b0;
            pc     <= `MIPS_RESET_VECTOR;
            npc    <= `MIPS_RESET_VECTOR + 4;
            jump_q <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    active <= 1'b1;  // First fetch request waits one cycle for this.
                    if (fetch_done) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    state <= S_EXECUTE;
                end
                S_EXECUTE: begin
                    jump_q <= branch_taken;
                    state  <= (is_load || is_store) ? S_MEM : S_WRITEBACK;
                end
                S_MEM: begin
                    if (mem_done) begin
                        state <= S_WRITEBACK;
                    end
                end
                S_WRITEBACK: begin
                    pc  <= npc;
                    npc <= jump_q ? target_q : npc + 4;
                    if (halting) begin
                        state  <= S_HALT;  // The delay slot of a jump to zero has retired.
                        active <= 1'b0;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                default: begin
                    state <= S_HALT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            ir <= readdata;
        end
        if (state == S_DECODE) begin
            rs_q <= regs.rs_data;
            rt_q <= regs.rt_data;
        end
        if (state == S_EXECUTE) begin
            alu_q    <= alu.result;
            target_q <= (opcode == OP_SPECIAL) ? rs_q : br_target;  // JR jumps to rs.
        end
        if (mem_done && is_load) begin
            mem_q <= readdata;
        end
    end

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(read && write))
        else $error("Read and write requested in the same cycle.");

    // A stalled request must be presented unchanged until the slave accepts it.
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) && (!write || $stable(writedata)))
        else $error("Avalon request changed while waitrequest was high.");

    a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (state == S_HALT) |-> !read && !write && !active)
        else $error("Memory request or active seen after halt.");

endmodule

//--- design/mips_cpu.sv
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_cpu (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic                        active,
    output logic [`MIPS_DATA_W-1:0]     register_v0,
    output logic [`MIPS_DATA_W-1:0]     address,
    output logic                        read,
    output logic                        write,
    output logic [`MIPS_DATA_W-1:0]     writedata,
    output logic [`MIPS_DATA_W/8-1:0]   byteenable,
    input  logic                        waitrequest,
    input  logic [`MIPS_DATA_W-1:0]     readdata
);

    reg_port_if reg_bus ();
    alu_if      alu_bus ();

    mips_controller ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .regs        (reg_bus.controller),
        .alu         (alu_bus.controller)
    );

    mips_alu alu_i (
        .alu (alu_bus.alu)
    );

    mips_reg_file rf_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .regs        (reg_bus.reg_file),
        .register_v0 (register_v0)
    );

endmodule

//--- design/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Width of instruction words, data words, addresses and registers.
`define MIPS_DATA_W 32

// First fetch address after reset.
// Address zero stays free so that it can serve as the halt target.
`define MIPS_RESET_VECTOR 32'h0000_0004

// A control transfer to this address ends execution once its delay slot retires.
`define MIPS_HALT_ADDR 32'h0000_0000

`endif

//--- design/mips_pkg.sv
package mips_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,            // R-type, the operation sits in the funct field.
        OP_REGIMM  = 6'h01,            // BLTZ and BGEZ, selected by the rt field.
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25
    } funct_e;

    typedef enum logic [4:0] {
        RI_BLTZ = 5'h00,
        RI_BGEZ = 5'h01
    } regimm_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LUI                        // Moves the low half of b into the upper half.
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEM,
        S_WRITEBACK,
        S_HALT
    } ctrl_state_e;

endpackage

//--- design/mips_reg_file.sv
`timescale 1ns/100ps
`include "mips_macros.svh"

module mips_reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    reg_port_if.reg_file            regs,
    output logic [`MIPS_DATA_W-1:0] register_v0
);

    localparam int NUM_REGS = 32;
    localparam int V0_INDEX = 2;

    logic [`MIPS_DATA_W-1:0] gpr_q [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                gpr_q[i] <= '0;
            end
        end else if (regs.wr_en && (regs.wr_addr != 5'd0)) begin
            gpr_q[regs.wr_addr] <= regs.wr_data;  // Register zero is never written.
        end
    end

    assign regs.rs_data = gpr_q[regs.rs_addr];  // Reads see the value before this edge.
    assign regs.rt_data = gpr_q[regs.rt_addr];

    assign register_v0 = gpr_q[V0_INDEX];

    // Register zero must stay zero in storage.
    a_zero_reg: assert property (@(posedge clk) disable iff (!rst_n) gpr_q[0] == '0)
        else $error("Register zero holds a nonzero value.");

endmodule

//--- design/reg_port_if.sv
`timescale 1ns/100ps
`include "mips_macros.svh"

interface reg_port_if ();

    logic [4:0]              rs_addr;
    logic [4:0]              rt_addr;
    logic [`MIPS_DATA_W-1:0] rs_data;  // Combinational read of rs.
    logic [`MIPS_DATA_W-1:0] rt_data;  // Combinational read of rt.
    logic                    wr_en;    // Write happens on the clock edge where this is high.
    logic [4:0]              wr_addr;
    logic [`MIPS_DATA_W-1:0] wr_data;

    modport controller (
        output rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        input  rs_data, rt_data
    );

    modport reg_file (
        input  rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        output rs_data, rt_data
    );

endinterface

//--- testbench/tb_avalon_ram.sv
`timescale 1ns/100ps
`include "mips_macros.svh"

module tb_avalon_ram (
    input  logic                      clk,
    input  logic [`MIPS_DATA_W-1:0]   address,
    input  logic                      read,
    input  logic                      write,
    input  logic [`MIPS_DATA_W-1:0]   writedata,
    input  logic [`MIPS_DATA_W/8-1:0] byteenable,
    output logic                      waitrequest,
    output logic [`MIPS_DATA_W-1:0]   readdata
);

    localparam int          DEPTH     = 256;  // 1 KiB of 32-bit words.
    localparam int          IDX_W     = 8;
    localparam logic [31:0] WAIT_SEED = 32'hbe2c_86bf;

    logic [`MIPS_DATA_W-1:0]   mem [DEPTH];
    logic [IDX_W-1:0]          index;
    logic                      request;
    logic [1:0]                wait_left;        // Wait cycles still owed to this request.
    logic [`MIPS_DATA_W/8-1:0] last_byteenable;  // Byte enables of the last completed write.

    assign index       = address[IDX_W+1:2];
    assign request     = (read === 1'b1) || (write === 1'b1);
    assign waitrequest = request && (wait_left != 2'd0);
    assign readdata    = (read === 1'b1) ? mem[index] : '0;

    // Every word gets a value built from its full index, so a stray access shows up.
    task automatic fill_memory();
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = {16'hdead, 16'(i)};
        end
        last_byteenable = '0;
    endtask

    task automatic load_word(input logic [31:0] byte_addr, input logic [31:0] data);
        mem[byte_addr[IDX_W+1:2]] = data;
    endtask

    function automatic logic [31:0] peek(input logic [31:0] byte_addr);
        return mem[byte_addr[IDX_W+1:2]];
    endfunction

    initial begin
        void'($urandom(WAIT_SEED));
        fill_memory();
        wait_left = 2'($urandom_range(3, 0));
        forever begin
            @(posedge clk);
            if (request) begin
                if (wait_left != 2'd0) begin
                    wait_left <= wait_left - 2'd1;
                end else begin
                    if (write === 1'b1) begin
                        mem[index]      <= writedata;
                        last_byteenable <= byteenable;
                    end
                    wait_left <= 2'($urandom_range(3, 0));  // Stall length of the next request.
                end
            end
        end
    end

endmodule

//--- testbench/tb_mips_cpu.sv
`timescale 1ns/100ps
`include "mips_macros.svh"

module tb_mips_cpu import mips_pkg::*; ();

    localparam int         RUN_LIMIT = 2000;  // Cycles one program may take before a timeout.
    localparam logic [4:0] R_ZERO    = 5'd0;
    localparam logic [4:0] R_V0      = 5'd2;
    localparam logic [4:0] R_T0      = 5'd8;
    localparam logic [4:0] R_T1      = 5'd9;
    localparam logic [4:0] R_T2      = 5'd10;

    logic        clk;
    logic        rst_n;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic        waitrequest;
    logic [31:0] readdata;
    logic [31:0] prog [$];

    mips_cpu dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    tb_avalon_ram ram_i (
        .clk         (clk),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] itype_word(input opcode_e op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] rtype_word(input funct_e fn, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] regimm_word(input regimm_e code, input logic [4:0] rs,
                                                input logic [15:0] offset);
        return {OP_REGIMM, rs, code, offset};
    endfunction

    function automatic logic [31:0] sign_extend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic fail_and_stop(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_and_stop($sformatf("** Error at time %0t: %s is 0x%08h, expected 0x%08h",
                                    $time, what, actual, expected));
        end
    endtask

    // Ends with JR $0 and the given delay-slot instruction.
    task automatic add_halt(input logic [31:0] slot_word);
        prog.push_back(rtype_word(FN_JR, R_ZERO, R_ZERO, R_ZERO));
        prog.push_back(slot_word);
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while ((active !== 1'b0) && (cycles < RUN_LIMIT)) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (active !== 1'b0) begin
            fail_and_stop($sformatf("Timeout: the program did not halt within %0d cycles.",
                                    RUN_LIMIT));
        end
    endtask

    task automatic run_program();
        rst_n = 1'b0;
        ram_i.fill_memory();
        foreach (prog[i]) begin
            ram_i.load_word(`MIPS_RESET_VECTOR + 4 * i, prog[i]);
        end
        repeat (3) begin
            @(posedge clk);
            #2;
            check_equal("read during reset", read, 1'b0);
            check_equal("write during reset", write, 1'b0);
            check_equal("active during reset", active, 1'b0);
        end
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        check_equal("active after reset release", active, 1'b1);  // Rises on the first clock.
        wait_for_halt();
    endtask

    task automatic test_arithmetic();
        logic [31:0] expected;
        prog.delete();
        prog.push_back(itype_word(OP_ADDIU, R_ZERO, R_T0, 16'd100));
        prog.push_back(itype_word(OP_ADDIU, R_ZERO, R_T1, 16'hffe2));  // Minus 30.
        prog.push_back(rtype_word(FN_ADDU, R_T0, R_T1, R_V0));
        prog.push_back(rtype_word(FN_SUBU, R_V0, R_T0, R_V0));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'hfffb));
        add_halt(rtype_word(FN_OR, R_ZERO, R_ZERO, R_ZERO));
        run_program();
        expected = 32'd100 + sign_extend(16'hffe2);
        expected = expected - 32'd100;
        expected = expected + sign_extend(16'hfffb);
        check_equal("arithmetic v0", register_v0, expected);
    endtask

    task automatic test_logic();
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] t2;
        prog.delete();
        prog.push_back(itype_word(OP_LUI, R_ZERO, R_T0, 16'h1234));
        prog.push_back(itype_word(OP_ORI, R_T0, R_T0, 16'hf0f0));
        prog.push_back(itype_word(OP_ANDI, R_T0, R_T1, 16'h8ff0));
        prog.push_back(itype_word(OP_LUI, R_ZERO, R_T2, 16'hff00));
        prog.push_back(rtype_word(FN_OR, R_T2, R_T1, R_T2));
        prog.push_back(rtype_word(FN_AND, R_T2, R_T0, R_V0));
        add_halt(rtype_word(FN_OR, R_ZERO, R_ZERO, R_ZERO));
        run_program();
        t0 = {16'h1234, 16'h0000} | {16'h0000, 16'hf0f0};  // ORI and ANDI zero-extend.
        t1 = t0 & {16'h0000, 16'h8ff0};
        t2 = {16'hff00, 16'h0000} | t1;
        check_equal("logic v0", register_v0, t2 & t0);
    endtask

    task automatic test_memory();
        logic [31:0] value;
        value = {16'hcafe, 16'h0000} | 32'h0000_1234;
        prog.delete();
        prog.push_back(itype_word(OP_LUI, R_ZERO, R_T0, 16'hcafe));
        prog.push_back(itype_word(OP_ORI, R_T0, R_T0, 16'h1234));
        prog.push_back(itype_word(OP_ADDIU, R_ZERO, R_T1, 16'h0080));
        prog.push_back(itype_word(OP_SW, R_T1, R_T0, 16'h0008));
        prog.push_back(itype_word(OP_ADDIU, R_T0, R_T2, 16'h0001));
        prog.push_back(itype_word(OP_SW, R_T1, R_T2, 16'hfffc));  // Negative offset.
        prog.push_back(itype_word(OP_LW, R_T1, R_V0, 16'h0008));
        add_halt(rtype_word(FN_OR, R_ZERO, R_ZERO, R_ZERO));
        run_program();
        check_equal("loaded v0", register_v0, value);
        check_equal("RAM word 0x88", ram_i.peek(32'h80 + sign_extend(16'h0008)), value);
        check_equal("RAM word 0x7c", ram_i.peek(32'h80 + sign_extend(16'hfffc)), value + 1);
        check_equal("byteenable of store", ram_i.last_byteenable, 4'hf);
    endtask

    task automatic test_regimm_branches();
        prog.delete();
        prog.push_back(itype_word(OP_ADDIU, R_ZERO, R_T0, 16'hffff));
        prog.push_back(regimm_word(RI_BGEZ, R_T0, 16'd2));  // Not taken on a negative rs.
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd1));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd2));
        prog.push_back(regimm_word(RI_BLTZ, R_T0, 16'd3));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd4));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd8));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd16));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd32));
        add_halt(rtype_word(FN_OR, R_ZERO, R_ZERO, R_ZERO));
        run_program();
        // Both delay slots and the fall-through run, the two BLTZ skips do not.
        check_equal("regimm v0", register_v0, 32'd1 + 32'd2 + 32'd4 + 32'd32);
    endtask

    task automatic test_equality_branches();
        prog.delete();
        prog.push_back(itype_word(OP_ADDIU, R_ZERO, R_T0, 16'd5));
        prog.push_back(itype_word(OP_ADDIU, R_ZERO, R_T1, 16'd5));
        prog.push_back(itype_word(OP_ADDIU, R_ZERO, R_T2, 16'd7));
        prog.push_back(itype_word(OP_BEQ, R_T0, R_T1, 16'd2));  // Taken.
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd1));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd2));
        prog.push_back(itype_word(OP_BNE, R_T0, R_T2, 16'd2));  // Taken.
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd4));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd8));
        prog.push_back(itype_word(OP_BEQ, R_T0, R_T2, 16'd2));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd16));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd32));
        prog.push_back(itype_word(OP_BNE, R_T0, R_T1, 16'd2));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd64));
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'd128));
        add_halt(rtype_word(FN_OR, R_ZERO, R_ZERO, R_ZERO));
        run_program();
        check_equal("equality v0", register_v0,
                    32'd1 + 32'd4 + 32'd16 + 32'd32 + 32'd64 + 32'd128);
    endtask

    task automatic test_reset_and_halt();
        prog.delete();
        prog.push_back(itype_word(OP_ADDIU, R_ZERO, R_V0, 16'd10));
        add_halt(itype_word(OP_ADDIU, R_V0, R_V0, 16'h0100));  // Only the slot adds 0x100.
        prog.push_back(itype_word(OP_ADDIU, R_V0, R_V0, 16'h0200));
        run_program();
        check_equal("v0 after halt", register_v0, 32'd10 + 32'h0100);
        repeat (3) begin
            @(posedge clk);
            #2;
            check_equal("active after halt", active, 1'b0);
            check_equal("read after halt", read, 1'b0);
            check_equal("write after halt", write, 1'b0);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        @(posedge clk);
        #2;
        test_arithmetic();
        test_logic();
        test_memory();
        test_regimm_branches();
        test_equality_branches();
        test_reset_and_halt();
        $display("All tests passed!");
        $finish;
    end

endmodule
